// ==== source/icache_pkg.sv ====
package icache_pkg;

    // address and cache geometry.
    localparam int addr_w         = 32;
    localparam int data_w         = 32;
    localparam int index_w        = 4;
    localparam int offset_w       = 2;
    localparam int tag_w          = addr_w - index_w - offset_w - 2;
    localparam int num_lines      = 1 << index_w;
    localparam int words_per_line = 1 << offset_w;

    // byte address split, msb first.
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
        logic [1:0]          byte_sel;
    } addr_fields_t;

    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } tag_entry_t;

    // fetch request from the cpu.
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } cpu_req_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
    } cpu_resp_t;

    // single word read toward memory, address is word aligned.
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
    } mem_req_t;

endpackage

// ==== source/icache_ram.sv ====
`timescale 1ns/10ps

module icache_ram #(
    parameter type entry_t = logic,
    parameter int  depth   = 16
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic                     we,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    // storage array, contents come from the controller's sweep or a refill.
    entry_t mem [depth];

    // write takes effect at the edge.
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
    end

    // registered read, old contents on a same-address write.
    always_ff @(posedge clk)
    begin
        rdata <= mem[addr];
    end

endmodule

// ==== source/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic                                                 flush,
    input  icache_pkg::cpu_req_t                                 cpu_req,
    output logic                                                 cpu_req_ready,
    output icache_pkg::cpu_resp_t                                cpu_resp,
    output icache_pkg::mem_req_t                                 mem_req,
    input  logic                                                 mem_req_ready,
    input  logic [icache_pkg::data_w-1:0]                        mem_rdata,
    output logic [icache_pkg::index_w-1:0]                       tag_addr,
    output logic                                                 tag_we,
    output icache_pkg::tag_entry_t                               tag_wdata,
    input  icache_pkg::tag_entry_t                               tag_rdata,
    output logic [icache_pkg::index_w+icache_pkg::offset_w-1:0]  data_addr,
    output logic                                                 data_we,
    output logic [icache_pkg::data_w-1:0]                        data_wdata,
    input  logic [icache_pkg::data_w-1:0]                        data_rdata
);
    import icache_pkg::*;

    typedef enum logic [1:0] {
        st_flush,
        st_lookup,
        st_refill,
        st_replay
    } state_t;

    state_t              state;
    state_t              state_next;
    addr_fields_t        req_in;
    addr_fields_t        req_q;      // address of the pending lookup.
    logic                pending;
    logic                hit;
    logic                accept;
    logic                take_flush;
    logic                mem_fire;
    logic                last_word;
    logic [index_w-1:0]  flush_cnt;
    logic [offset_w-1:0] refill_cnt;

    assign req_in = cpu_req.addr;

    // tag compare on the entry read for the held address.
    assign hit = (state == st_lookup) && pending &&
                 tag_rdata.valid && (tag_rdata.tag == req_q.tag);

    // flush only between requests.
    assign take_flush = (state == st_lookup) && !pending && flush;

    // stays up while the pending lookup hits, so hits stream.
    assign cpu_req_ready = (state == st_lookup) && !take_flush && (!pending || hit);
    assign accept        = cpu_req.valid && cpu_req_ready;

    assign mem_fire  = mem_req.valid && mem_req_ready;
    assign last_word = (refill_cnt == offset_w'(words_per_line - 1));

    assign cpu_resp = cpu_resp_t'{valid: hit, data: data_rdata};

    // one word per read, offsets in order.
    assign mem_req = mem_req_t'{
        valid: (state == st_refill),
        addr:  {req_q.tag, req_q.index, refill_cnt, 2'b00}
    };

    always_comb
    begin
        state_next = state;
        case (state)
            st_flush:
            begin
                if (flush_cnt == index_w'(num_lines - 1))
                begin
                    state_next = st_lookup;
                end
            end
            st_lookup:
            begin
                if (take_flush)
                begin
                    state_next = st_flush;
                end
                else if (pending && !hit)
                begin
                    state_next = st_refill;
                end
            end
            st_refill:
            begin
                if (mem_fire && last_word)
                begin
                    state_next = st_replay;
                end
            end
            st_replay:
            begin
                state_next = st_lookup; // arrays re-read, answer from the new line.
            end
            default:
            begin
                state_next = st_flush;
            end
        endcase
    end

    // array control.
    always_comb
    begin
        tag_addr   = req_q.index;
        tag_we     = 1'b0;
        tag_wdata  = '0;
        data_addr  = {req_q.index, req_q.offset};
        data_we    = 1'b0;
        data_wdata = mem_rdata;
        case (state)
            st_flush:
            begin
                tag_addr = flush_cnt; // clear one valid bit per cycle.
                tag_we   = 1'b1;
            end
            st_lookup:
            begin
                if (accept)
                begin
                    tag_addr  = req_in.index;
                    data_addr = {req_in.index, req_in.offset};
                end
            end
            st_refill:
            begin
                data_addr = {req_q.index, refill_cnt};
                data_we   = mem_fire;
                if (mem_fire && last_word)
                begin
                    // line is complete, mark it valid.
                    tag_we          = 1'b1;
                    tag_wdata.valid = 1'b1;
                    tag_wdata.tag   = req_q.tag;
                end
            end
            default:
            begin
                tag_we  = 1'b0;
                data_we = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= st_flush;
            pending    <= 1'b0;
            flush_cnt  <= '0;
            refill_cnt <= '0;
        end
        else
        begin
            state <= state_next;
            if (accept)
            begin
                pending <= 1'b1;
            end
            else if (hit)
            begin
                pending <= 1'b0;
            end
            if (state == st_flush)
            begin
                flush_cnt <= flush_cnt + 1'b1; // wraps to zero at the end.
            end
            if (mem_fire)
            begin
                refill_cnt <= refill_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_q <= req_in;
        end
    end

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/10ps

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          flush,
    input  icache_pkg::cpu_req_t          cpu_req,
    output logic                          cpu_req_ready,
    output icache_pkg::cpu_resp_t         cpu_resp,
    output icache_pkg::mem_req_t          mem_req,
    input  logic                          mem_req_ready,
    input  logic [icache_pkg::data_w-1:0] mem_rdata
);
    import icache_pkg::*;

    logic [index_w-1:0]          tag_addr;
    logic                        tag_we;
    tag_entry_t                  tag_wdata;
    tag_entry_t                  tag_rdata;
    logic [index_w+offset_w-1:0] data_addr;
    logic                        data_we;
    logic [data_w-1:0]           data_wdata;
    logic [data_w-1:0]           data_rdata;

    icache_ctrl ctrl (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .cpu_resp      (cpu_resp),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rdata     (mem_rdata),
        .tag_addr      (tag_addr),
        .tag_we        (tag_we),
        .tag_wdata     (tag_wdata),
        .tag_rdata     (tag_rdata),
        .data_addr     (data_addr),
        .data_we       (data_we),
        .data_wdata    (data_wdata),
        .data_rdata    (data_rdata)
    );

    // one entry per line.
    icache_ram #(
        .entry_t (tag_entry_t),
        .depth   (num_lines)
    ) tag_store (
        .clk   (clk),
        .addr  (tag_addr),
        .we    (tag_we),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    // one entry per word, indexed by line and offset.
    icache_ram #(
        .entry_t (logic [data_w-1:0]),
        .depth   (num_lines * words_per_line)
    ) data_store (
        .clk   (clk),
        .addr  (data_addr),
        .we    (data_we),
        .wdata (data_wdata),
        .rdata (data_rdata)
    );

endmodule

// ==== tests/icache_assert.sv ====
`timescale 1ns/10ps

module icache_assert (
    input logic                  clk,
    input logic                  rst,
    input icache_pkg::cpu_req_t  cpu_req,
    input logic                  cpu_req_ready,
    input icache_pkg::cpu_resp_t cpu_resp,
    input icache_pkg::mem_req_t  mem_req,
    input logic                  mem_req_ready
);

    int   outstanding;  // accepted minus answered.
    logic in_refill;    // from the first memory read to the replayed response.
    bit   stable_err = 1'b0;
    bit   resp_err   = 1'b0;
    bit   ready_err  = 1'b0;
    bit   order_err  = 1'b0;
    logic any_failed;

    assign any_failed = stable_err | resp_err | ready_err | order_err;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            outstanding <= 0;
        end
        else
        begin
            outstanding <= outstanding + ((cpu_req.valid && cpu_req_ready) ? 1 : 0)
                         - (cpu_resp.valid ? 1 : 0);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            in_refill <= 1'b0;
        end
        else if (cpu_resp.valid)
        begin
            in_refill <= 1'b0;
        end
        else if (mem_req.valid)
        begin
            in_refill <= 1'b1;
        end
    end

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_req_ready |=> mem_req.valid && $stable(mem_req.addr))
    else
    begin
        $error("mem_req dropped or moved before ready");
        stable_err = 1'b1;
    end

    resp_after_req: assert property (@(posedge clk) disable iff (rst)
        cpu_resp.valid |-> outstanding > 0)
    else
    begin
        $error("response with nothing accepted");
        resp_err = 1'b1;
    end

    no_ready_in_refill: assert property (@(posedge clk) disable iff (rst)
        (mem_req.valid || in_refill) && !cpu_resp.valid |-> !cpu_req_ready)
    else
    begin
        $error("cpu_req_ready high during refill");
        ready_err = 1'b1;
    end

    // refill starts at offset 0 and steps by one.
    first_offset: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req.valid) |-> mem_req.addr[3:2] == 2'd0)
    else
    begin
        $error("refill did not start at offset 0");
        order_err = 1'b1;
    end

    next_offset: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && mem_req_ready && mem_req.addr[3:2] != 2'd3
        |=> mem_req.valid && mem_req.addr[3:2] == $past(mem_req.addr[3:2]) + 2'd1)
    else
    begin
        $error("refill offsets out of order");
        order_err = 1'b1;
    end

endmodule

bind icache_top icache_assert assert_inst (
    .clk           (clk),
    .rst           (rst),
    .cpu_req       (cpu_req),
    .cpu_req_ready (cpu_req_ready),
    .cpu_resp      (cpu_resp),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready)
);

// ==== tests/icache_tb.sv ====
`timescale 1ns/10ps

module icache_tb;
    import icache_pkg::*;

    localparam int          clk_period     = 4;
    localparam int          ready_timeout  = 200;
    localparam int          drain_timeout  = 400;
    localparam int          random_fetches = 300;
    localparam logic [31:0] mem_key        = 32'h5a3c_96e1;

    logic         clk = 1'b0;
    logic         rst;
    logic         flush;
    cpu_req_t     cpu_req;
    logic         cpu_req_ready;
    cpu_resp_t    cpu_resp;
    mem_req_t     mem_req;
    logic         mem_req_ready;
    logic [31:0]  mem_rdata;

    integer       seed = 32'h8b9e0e6e;
    int           mem_reads = 0;
    int           misses = 0;
    bit           last_hit = 1'b0;
    logic         model_valid [16];  // reference tags, one per line.
    logic [23:0]  model_tag [16];
    logic [31:0]  exp_resp [$];
    time          exp_due [$];       // response time of a predicted hit, 0 for a miss.
    logic [31:0]  exp_mem [$];       // word addresses of predicted refills.

    icache_top icache_top_inst (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .cpu_resp      (cpu_resp),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rdata     (mem_rdata)
    );

    always #(clk_period / 2) clk = ~clk;

    // backing memory contents.
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[24:0], addr[31:25]} ^ mem_key;
    endfunction

    // predicts hit or miss, a miss installs the line.
    function automatic bit lookup_model(input logic [31:0] addr);
        logic [3:0]  index;
        logic [23:0] tag;
        index = addr[7:4];
        tag   = addr[31:8];
        if (model_valid[index] && model_tag[index] == tag)
        begin
            return 1'b1;
        end
        model_valid[index] = 1'b1;
        model_tag[index]   = tag;
        return 1'b0;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic expect_reads(input int expected);
        assert (mem_reads == expected)
        else stop_with_error($sformatf("** Error at %0t: mem_reads = %0d, expected %0d",
                                       $time, mem_reads, expected));
    endtask

    task automatic idle_cycle();
        cpu_req <= '0;
        @(posedge clk);
    endtask

    task automatic wait_for_ready();
        int waited;
        waited = 0;
        while (!cpu_req_ready)
        begin
            waited++;
            assert (waited < ready_timeout)
            else stop_with_error("cpu_req_ready did not rise in time");
            @(posedge clk);
        end
    endtask

    task automatic fetch(input logic [31:0] addr);
        int waited;
        int w;
        bit is_hit;
        waited = 0;
        cpu_req <= '{valid: 1'b1, addr: addr};
        @(posedge clk);
        // a hit keeps the port open for the next fetch.
        assert (!last_hit || cpu_req_ready)
        else stop_with_error($sformatf("** Error at %0t: cpu_req_ready = %b, expected 1",
                                       $time, cpu_req_ready));
        while (!cpu_req_ready)
        begin
            waited++;
            assert (waited < ready_timeout)
            else stop_with_error("fetch was not accepted in time");
            @(posedge clk);
        end
        is_hit = lookup_model(addr);
        if (!is_hit) // whole line comes in, offsets 0 to 3.
        begin
            misses++;
            for (w = 0; w < 4; w++)
            begin
                exp_mem.push_back({addr[31:4], w[1:0], 2'b00});
            end
        end
        exp_resp.push_back(mem_word({addr[31:2], 2'b00}));
        exp_due.push_back(is_hit ? $time + clk_period : 0);
        last_hit = is_hit;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        cpu_req <= '0;
        while (exp_resp.size() != 0 || exp_mem.size() != 0)
        begin
            waited++;
            assert (waited < drain_timeout)
            else stop_with_error("outstanding responses did not arrive in time");
            @(posedge clk);
        end
        expect_reads(4 * misses);
    endtask

    task automatic flush_cache();
        int i;
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        for (i = 0; i < 16; i++)
        begin
            model_valid[i] = 1'b0;
        end
        wait_for_ready();
    endtask

    // memory answers each word after 0 to 3 wait cycles.
    initial
    begin
        int mem_wait;
        mem_req_ready <= 1'b0;
        mem_rdata     <= '0;
        mem_wait = $random(seed) & 3;
        forever
        begin
            @(posedge clk);
            if (rst || mem_req_ready)
            begin
                mem_req_ready <= 1'b0;
            end
            else if (mem_req.valid)
            begin
                if (mem_wait == 0)
                begin
                    mem_req_ready <= 1'b1;
                    mem_rdata     <= mem_word(mem_req.addr);
                    mem_wait = $random(seed) & 3;
                end
                else
                begin
                    mem_wait = mem_wait - 1;
                end
            end
        end
    end

    always @(posedge clk)
    begin
        logic [31:0] want;
        if (mem_req.valid && mem_req_ready)
        begin
            assert (exp_mem.size() > 0)
            else stop_with_error("memory read without a predicted miss");
            want = exp_mem.pop_front();
            assert (mem_req.addr == want)
            else stop_with_error($sformatf("** Error at %0t: mem_req.addr = %h, expected %h",
                                           $time, mem_req.addr, want));
            mem_reads++;
        end
    end

    // compare process.
    always @(posedge clk)
    begin
        logic [31:0] want;
        time         due;
        if (cpu_resp.valid)
        begin
            assert (exp_resp.size() > 0)
            else stop_with_error("response without an accepted request");
            want = exp_resp.pop_front();
            due  = exp_due.pop_front();
            assert (cpu_resp.data == want)
            else stop_with_error($sformatf("** Error at %0t: cpu_resp.data = %h, expected %h",
                                           $time, cpu_resp.data, want));
            assert (due == 0 || $time == due)
            else stop_with_error($sformatf("hit response came at %0t, expected at %0t",
                                           $time, due));
        end
    end

    // bound checker raises its flag on a failed property.
    always @(posedge clk)
    begin
        assert (!icache_top_inst.assert_inst.any_failed)
        else stop_with_error("a bound handshake assertion fired");
    end

    initial
    begin
        int          i;
        int          n;
        logic [31:0] r;
        rst     <= 1'b1;
        flush   <= 1'b0;
        cpu_req <= '0;
        for (i = 0; i < 16; i++)
        begin
            model_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        wait_for_ready(); // sweep done.

        fetch(32'h0000_2048); // cold miss.
        drain();
        expect_reads(4);

        fetch(32'h0000_2040);
        fetch(32'h0000_2044);
        fetch(32'h0000_204c);
        fetch(32'h0000_2049);
        idle_cycle();
        fetch(32'h0000_2042);
        drain();
        expect_reads(4);

        // same index, different tags.
        fetch(32'h0000_1234);
        fetch(32'h0004_5634);
        fetch(32'h0000_1234);
        fetch(32'h0004_5634);
        drain();
        expect_reads(20);

        for (i = 0; i < 8; i++)
        begin
            fetch(32'h0001_0000 + i * 16);
        end
        drain();
        n = mem_reads;
        for (i = 0; i < 8; i++)
        begin
            fetch(32'h0001_0004 + i * 16);
        end
        drain();
        expect_reads(n);
        flush_cache();
        for (i = 0; i < 8; i++)
        begin
            fetch(32'h0001_0008 + i * 16);
        end
        drain();
        expect_reads(n + 32);

        for (n = 0; n < random_fetches; n++)
        begin
            r = $random(seed);
            if (r[12])
            begin
                idle_cycle();
            end
            fetch({16'h0010, 6'h00, r[9:8], 2'b00, r[5:4], r[3:0]});
        end
        drain();
        @(posedge clk); // last cycle seen by the checker.

        if (icache_top_inst.assert_inst.any_failed)
        begin
            stop_with_error("a bound handshake assertion fired");
        end
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
source/icache_pkg.sv
source/icache_ram.sv
source/icache_ctrl.sv
source/icache_top.sv
tests/icache_assert.sv
tests/icache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
